/* verilog.f */
source/lite_core_pkg.sv
source/pipe_if.sv
source/reg_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/lite_core_top.sv
verification/lite_core_chk.sv
verification/lite_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --assert --top-module lite_core_tb -f verilog.f -o lite_core_sim
./obj_dir/lite_core_sim 2>&1 | tee sim.log

if grep -q "Something failed" sim.log; then
    exit 1
fi

/* verification/lite_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module lite_core_tb;
    import lite_core_pkg::*;

    typedef struct {
        string       test;
        word_t       pc;
        reg_addr_t   wnum;
        logic [3:0]  wen;
        word_t       wdata;
        int unsigned cycle;
    } trace_t;

    localparam int unsigned drain_timeout = 200;

    logic       aclk;
    logic       arst_n;
    logic       inst_valid;
    word_t      inst_pc;
    word_t      inst;
    logic       debug_wb_valid;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_wen;
    reg_addr_t  debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    word_t       shadow [32];
    trace_t      exp_q [$];
    string       test_name;
    word_t       next_pc;
    int unsigned cycle_cnt;
    int unsigned mismatches;
    int unsigned other_errors;

    lite_core_top dut (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .inst_valid        (inst_valid),
        .inst_pc           (inst_pc),
        .inst              (inst),
        .debug_wb_valid    (debug_wb_valid),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #20 aclk = ~aclk;

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic word_t enc_3r(input logic [16:0] op, input reg_addr_t rd,
                                     input reg_addr_t rj, input reg_addr_t rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic word_t enc_addi(input reg_addr_t rd, input reg_addr_t rj,
                                       input logic [11:0] si12);
        return {op_addi, si12, rj, rd};
    endfunction

    function automatic word_t enc_lu12i(input reg_addr_t rd, input logic [19:0] si20);
        return {op_lu12i, si20, rd};
    endfunction

    function automatic logic [16:0] op_3r_at(input logic [2:0] k);
        case (k)
            3'd0:    return op_add_w;
            3'd1:    return op_sub_w;
            3'd2:    return op_slt;
            3'd3:    return op_sltu;
            3'd4:    return op_nor;
            3'd5:    return op_and;
            3'd6:    return op_or;
            default: return op_xor;
        endcase
    endfunction

    function automatic reg_addr_t rand_reg(input int unsigned lo, input int unsigned hi);
        word_t r;
        r = $urandom_range(hi, lo);
        return r[4:0];
    endfunction

    function automatic word_t random_inst();
        word_t r;
        r = $urandom;
        case (r[1:0])
            2'd0:    return enc_addi(rand_reg(0, 15), rand_reg(0, 15), r[31:20]);
            2'd1:    return enc_lu12i(rand_reg(0, 15), r[31:12]);
            // top bits all ones match no opcode
            2'd2:    return {6'h3f, r[31:6]};
            default: return enc_3r(op_3r_at(r[4:2]), rand_reg(0, 15), rand_reg(0, 15),
                                   rand_reg(0, 15));
        endcase
    endfunction

    // architectural value of one instruction from its source registers
    function automatic word_t exp_result(input word_t ins, input word_t a, input word_t b);
        word_t imm12;
        imm12 = {{20{ins[21]}}, ins[21:10]};
        if (ins[31:22] == op_addi) begin
            return a + imm12;
        end
        if (ins[31:25] == op_lu12i) begin
            return {ins[24:5], 12'h000};
        end
        case (ins[31:15])
            op_add_w: return a + b;
            op_sub_w: return a - b;
            op_slt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_sltu:  return (a < b) ? 32'd1 : 32'd0;
            op_nor:   return ~(a | b);
            op_and:   return a & b;
            op_or:    return a | b;
            op_xor:   return a ^ b;
            default:  return '0;
        endcase
    endfunction

    task automatic check_value(input string what, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected %h, actual %h", what, expected, actual);
            mismatches++;
        end
    endtask

    // idle gap, then one instruction on the falling edge
    task automatic issue(input word_t ins, input int unsigned max_gap);
        trace_t      t;
        int unsigned gap;
        logic        known;
        gap = $urandom_range(max_gap, 0);
        repeat (gap) begin
            @(negedge aclk);
            inst_valid = 1'b0;
        end
        @(negedge aclk);
        inst_valid = 1'b1;
        inst_pc    = next_pc;
        inst       = ins;
        known = (ins[31:22] == op_addi) || (ins[31:25] == op_lu12i)
                || (ins[31:15] inside {op_add_w, op_sub_w, op_slt, op_sltu,
                                       op_nor, op_and, op_or, op_xor});
        t.test  = test_name;
        t.pc    = next_pc;
        t.wnum  = ins[4:0];
        t.wen   = (known && ins[4:0] != 5'd0) ? 4'hf : 4'h0;
        t.wdata = exp_result(ins, shadow[ins[9:5]], shadow[ins[14:10]]);
        t.cycle = cycle_cnt;
        exp_q.push_back(t);
        if (t.wen != 4'h0) begin
            shadow[t.wnum] = t.wdata;
        end
        next_pc = next_pc + 32'd4;
    endtask

    always @(negedge aclk) begin : compare_trace
        trace_t t;
        if (!arst_n) begin
            if (debug_wb_valid) begin
                $display("trace seen while reset is asserted");
                other_errors++;
            end
        end else if (debug_wb_valid) begin
            if (exp_q.size() == 0) begin
                $display("trace at pc %h with no instruction outstanding", debug_wb_pc);
                other_errors++;
            end else begin
                t = exp_q.pop_front();
                check_value({t.test, " pc"}, t.pc, debug_wb_pc);
                check_value({t.test, " wen"}, 32'(t.wen), 32'(debug_wb_rf_wen));
                check_value({t.test, " latency"}, t.cycle + 3, cycle_cnt);
                if (t.wen != 4'h0) begin
                    check_value({t.test, " wnum"}, 32'(t.wnum), 32'(debug_wb_rf_wnum));
                    check_value({t.test, " wdata"}, t.wdata, debug_wb_rf_wdata);
                end
            end
        end
    end

    initial begin
        word_t       r;
        int unsigned wait_cnt;
        aclk         = 1'b0;
        arst_n       = 1'b0;
        inst_valid   = 1'b0;
        inst_pc      = '0;
        inst         = '0;
        cycle_cnt    = 0;
        mismatches   = 0;
        other_errors = 0;
        next_pc      = 32'h1c00_0000;
        shadow       = '{default: '0};
        test_name    = "reset_state";
        void'($urandom(37));
        // instructions offered while in reset must never reach the trace
        repeat (15) begin
            @(negedge aclk);
            inst_valid = 1'b1;
            inst_pc    = $urandom;
            inst       = random_inst();
        end
        @(negedge aclk);
        inst_valid = 1'b0;
        arst_n     = 1'b1;

        for (int i = 0; i < 32; i++) begin
            issue(enc_3r(op_or, reg_addr_t'(i), reg_addr_t'(i), 5'd0), 1);
        end

        // operands loaded by lu12i.w then addi.w
        test_name = "operations";
        repeat (6) begin
            for (int i = 1; i < 8; i++) begin
                r = $urandom;
                issue(enc_lu12i(reg_addr_t'(i), r[31:12]), 2);
                issue(enc_addi(reg_addr_t'(i), reg_addr_t'(i), r[11:0]), 2);
            end
            for (int k = 0; k < 8; k++) begin
                issue(enc_3r(op_3r_at(3'(k)), rand_reg(8, 15), rand_reg(1, 7),
                             rand_reg(1, 7)), 2);
            end
        end

        // no gaps, few registers, so sources hit one and two back
        test_name = "bypass";
        repeat (6) begin
            r = $urandom;
            issue(enc_addi(5'd1, 5'd1, r[11:0]), 0);
            issue(enc_3r(op_add_w, 5'd2, 5'd1, 5'd2), 0);
            issue(enc_3r(op_sub_w, 5'd3, 5'd2, 5'd1), 0);
        end
        repeat (40) begin
            r = $urandom;
            issue(enc_3r(op_3r_at(r[2:0]), rand_reg(1, 4), rand_reg(1, 4), rand_reg(1, 4)), 0);
        end

        test_name = "register_zero";
        issue(enc_3r(op_add_w, 5'd0, 5'd1, 5'd2), 1);
        issue(enc_lu12i(5'd0, 20'hfffff), 0);
        issue(enc_addi(5'd0, 5'd0, 12'h123), 0);
        issue(enc_3r(op_or, 5'd5, 5'd0, 5'd0), 0);
        issue(enc_3r(op_sltu, 5'd6, 5'd0, 5'd1), 0);
        issue(enc_addi(5'd7, 5'd0, 12'h800), 1);

        test_name = "unknown";
        repeat (10) begin
            r = $urandom;
            issue({6'h3f, r[25:0]}, 2);
        end
        for (int i = 1; i < 32; i++) begin
            issue(enc_3r(op_or, reg_addr_t'(i), reg_addr_t'(i), 5'd0), 0);
        end

        test_name = "random_gaps";
        repeat (80) begin
            issue(random_inst(), 4);
        end

        @(negedge aclk);
        inst_valid = 1'b0;
        wait_cnt   = 0;
        while (exp_q.size() != 0 && wait_cnt < drain_timeout) begin
            @(negedge aclk);
            wait_cnt++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d traces never appeared", exp_q.size());
            other_errors++;
        end
        // a few more cycles to catch stray traces
        repeat (4) @(negedge aclk);

        $display("mismatches %0d, other errors %0d", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/lite_core_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module lite_core_chk (
    input logic                     aclk,
    input logic                     arst_n,
    input logic                     inst_valid,
    input logic                     debug_wb_valid,
    input logic [3:0]               debug_wb_rf_wen,
    input lite_core_pkg::reg_addr_t debug_wb_rf_wnum
);
    logic [1:0] live_cycles;

    // cycles since reset release, saturating
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            live_cycles <= 2'd0;
        end else if (live_cycles != 2'd3) begin
            live_cycles <= live_cycles + 2'd1;
        end
    end

    quiet_in_reset: assert property (@(posedge aclk) !arst_n |-> !debug_wb_valid)
        else $error("trace valid while reset is asserted");

    wen_needs_valid: assert property (@(posedge aclk) disable iff (!arst_n)
        (debug_wb_rf_wen != 4'h0) |-> (debug_wb_valid && debug_wb_rf_wnum != 5'd0))
        else $error("trace write enable without valid or with r0");

    // three-stage latency
    fixed_latency: assert property (@(posedge aclk) disable iff (!arst_n)
        (live_cycles == 2'd3) |-> (debug_wb_valid == $past(inst_valid, 3)))
        else $error("trace valid does not follow inst_valid by three cycles");

endmodule

bind lite_core_top lite_core_chk u_chk (
    .aclk             (aclk),
    .arst_n           (arst_n),
    .inst_valid       (inst_valid),
    .debug_wb_valid   (debug_wb_valid),
    .debug_wb_rf_wen  (debug_wb_rf_wen),
    .debug_wb_rf_wnum (debug_wb_rf_wnum)
);

`default_nettype wire

/* source/lite_core_top.sv */
`timescale 1ns/1ns
`default_nettype none

module lite_core_top (
    input  logic                     aclk,
    input  logic                     arst_n,
    input  logic                     inst_valid,
    input  lite_core_pkg::word_t     inst_pc,
    input  lite_core_pkg::word_t     inst,
    output logic                     debug_wb_valid,
    output lite_core_pkg::word_t     debug_wb_pc,
    output logic [3:0]               debug_wb_rf_wen,
    output lite_core_pkg::reg_addr_t debug_wb_rf_wnum,
    output lite_core_pkg::word_t     debug_wb_rf_wdata
);
    import lite_core_pkg::*;

    logic      wb_wen;
    reg_addr_t wb_waddr;
    word_t     wb_wdata;
    reg_addr_t raddr_a;
    reg_addr_t raddr_b;
    word_t     rdata_a;
    word_t     rdata_b;

    decode_exec_if de_bus ();
    exec_result_if er_bus ();

    reg_file u_reg_file (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .wen     (wb_wen),
        .waddr   (wb_waddr),
        .wdata   (wb_wdata)
    );

    decode_stage u_decode_stage (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst_pc    (inst_pc),
        .inst       (inst),
        .out        (de_bus.producer),
        .fwd        (er_bus.bypass),
        .wb_wen     (wb_wen),
        .wb_waddr   (wb_waddr),
        .wb_wdata   (wb_wdata),
        .raddr_a    (raddr_a),
        .raddr_b    (raddr_b),
        .rdata_a    (rdata_a),
        .rdata_b    (rdata_b)
    );

    execute_stage u_execute_stage (
        .aclk   (aclk),
        .arst_n (arst_n),
        .in     (de_bus.consumer),
        .out    (er_bus.producer)
    );

    result_stage u_result_stage (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .in                (er_bus.consumer),
        .wb_wen            (wb_wen),
        .wb_waddr          (wb_waddr),
        .wb_wdata          (wb_wdata),
        .debug_wb_valid    (debug_wb_valid),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

`default_nettype wire

/* source/result_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module result_stage (
    input  logic                     aclk,
    input  logic                     arst_n,
    exec_result_if.consumer          in,
    output logic                     wb_wen,
    output lite_core_pkg::reg_addr_t wb_waddr,
    output lite_core_pkg::word_t     wb_wdata,
    output logic                     debug_wb_valid,
    output lite_core_pkg::word_t     debug_wb_pc,
    output logic [3:0]               debug_wb_rf_wen,
    output lite_core_pkg::reg_addr_t debug_wb_rf_wnum,
    output lite_core_pkg::word_t     debug_wb_rf_wdata
);
    import lite_core_pkg::*;

    logic      valid_q;
    word_t     pc_q;
    reg_addr_t dest_q;
    logic      wen_q;
    word_t     result_q;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in.valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (in.valid) begin
            pc_q     <= in.pc;
            dest_q   <= in.dest;
            wen_q    <= in.wen;
            result_q <= in.result;
        end
    end

    assign wb_wen   = valid_q & wen_q;
    assign wb_waddr = dest_q;
    assign wb_wdata = result_q;

    // trace mirrors the write port
    assign debug_wb_valid    = valid_q;
    assign debug_wb_pc       = pc_q;
    assign debug_wb_rf_wen   = wb_wen ? trace_wen_all : 4'h0;
    assign debug_wb_rf_wnum  = dest_q;
    assign debug_wb_rf_wdata = result_q;

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic              aclk,
    input  logic              arst_n,
    decode_exec_if.consumer   in,
    exec_result_if.producer   out
);
    import lite_core_pkg::*;

    logic      valid_q;
    word_t     pc_q;
    alu_op_e   op_q;
    word_t     src_a_q;
    word_t     src_b_q;
    reg_addr_t dest_q;
    logic      wen_q;
    word_t     result;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in.valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (in.valid) begin
            pc_q    <= in.pc;
            op_q    <= in.op;
            src_a_q <= in.src_a;
            src_b_q <= in.src_b;
            dest_q  <= in.dest;
            wen_q   <= in.wen;
        end
    end

    always_comb begin
        case (op_q)
            alu_add:  result = src_a_q + src_b_q;
            alu_sub:  result = src_a_q - src_b_q;
            alu_slt:  result = {{(word_w-1){1'b0}}, $signed(src_a_q) < $signed(src_b_q)};
            alu_sltu: result = {{(word_w-1){1'b0}}, src_a_q < src_b_q};
            alu_nor:  result = ~(src_a_q | src_b_q);
            alu_and:  result = src_a_q & src_b_q;
            alu_or:   result = src_a_q | src_b_q;
            alu_xor:  result = src_a_q ^ src_b_q;
            alu_lui:  result = src_b_q;
            default:  result = '0;
        endcase
    end

    // unregistered so decode can bypass it this cycle
    assign out.valid  = valid_q;
    assign out.pc     = pc_q;
    assign out.dest   = dest_q;
    assign out.wen    = wen_q;
    assign out.result = result;

endmodule

`default_nettype wire

/* source/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  logic                     aclk,
    input  logic                     arst_n,
    input  logic                     inst_valid,
    input  lite_core_pkg::word_t     inst_pc,
    input  lite_core_pkg::word_t     inst,
    decode_exec_if.producer          out,
    exec_result_if.bypass            fwd,
    input  logic                     wb_wen,
    input  lite_core_pkg::reg_addr_t wb_waddr,
    input  lite_core_pkg::word_t     wb_wdata,
    output lite_core_pkg::reg_addr_t raddr_a,
    output lite_core_pkg::reg_addr_t raddr_b,
    input  lite_core_pkg::word_t     rdata_a,
    input  lite_core_pkg::word_t     rdata_b
);
    import lite_core_pkg::*;

    logic      valid_q;
    word_t     pc_q;
    word_t     inst_q;
    alu_op_e   op;
    logic      use_imm;
    word_t     imm;
    reg_addr_t rd;
    reg_addr_t rj;
    reg_addr_t rk;
    logic      ex_hit_a;
    logic      ex_hit_b;
    logic      wb_hit_a;
    logic      wb_hit_b;
    word_t     opnd_a;
    word_t     opnd_b;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= inst_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (inst_valid) begin
            pc_q   <= inst_pc;
            inst_q <= inst;
        end
    end

    assign rd = inst_q[4:0];
    assign rj = inst_q[9:5];
    assign rk = inst_q[14:10];

    always_comb begin
        op      = alu_no_op;
        use_imm = 1'b0;
        case (inst_q[31:15])
            op_add_w: op = alu_add;
            op_sub_w: op = alu_sub;
            op_slt:   op = alu_slt;
            op_sltu:  op = alu_sltu;
            op_nor:   op = alu_nor;
            op_and:   op = alu_and;
            op_or:    op = alu_or;
            op_xor:   op = alu_xor;
            default: begin
                if (inst_q[31:22] == op_addi) begin
                    op      = alu_add;
                    use_imm = 1'b1;
                end else if (inst_q[31:25] == op_lu12i) begin
                    op      = alu_lui;
                    use_imm = 1'b1;
                end
            end
        endcase
    end

    // si20 into the upper bits, si12 sign-extended
    assign imm = (op == alu_lui) ? {inst_q[24:5], 12'b0}
                                 : {{20{inst_q[21]}}, inst_q[21:10]};

    assign raddr_a = rj;
    assign raddr_b = rk;

    // execute result wins over the pending write-back
    assign ex_hit_a = fwd.valid && fwd.wen && (fwd.dest == rj);
    assign ex_hit_b = fwd.valid && fwd.wen && (fwd.dest == rk);
    assign wb_hit_a = wb_wen && (wb_waddr == rj);
    assign wb_hit_b = wb_wen && (wb_waddr == rk);

    assign opnd_a = ex_hit_a ? fwd.result : (wb_hit_a ? wb_wdata : rdata_a);
    assign opnd_b = ex_hit_b ? fwd.result : (wb_hit_b ? wb_wdata : rdata_b);

    assign out.valid = valid_q;
    assign out.pc    = pc_q;
    assign out.op    = op;
    assign out.src_a = opnd_a;
    assign out.src_b = use_imm ? imm : opnd_b;
    assign out.dest  = rd;
    assign out.wen   = (op != alu_no_op) && (rd != '0);

endmodule

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic                   aclk,
    input  logic                   arst_n,
    input  lite_core_pkg::reg_addr_t raddr_a,
    input  lite_core_pkg::reg_addr_t raddr_b,
    output lite_core_pkg::word_t   rdata_a,
    output lite_core_pkg::word_t   rdata_b,
    input  logic                   wen,
    input  lite_core_pkg::reg_addr_t waddr,
    input  lite_core_pkg::word_t   wdata
);
    import lite_core_pkg::*;

    word_t regs [32];

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

/* source/pipe_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface decode_exec_if;
    import lite_core_pkg::*;

    logic      valid;
    word_t     pc;
    alu_op_e   op;
    word_t     src_a;
    word_t     src_b;
    reg_addr_t dest;
    logic      wen;

    modport producer (
        output valid, pc, op, src_a, src_b, dest, wen
    );

    modport consumer (
        input valid, pc, op, src_a, src_b, dest, wen
    );
endinterface

interface exec_result_if;
    import lite_core_pkg::*;

    logic      valid;
    word_t     pc;
    reg_addr_t dest;
    logic      wen;
    word_t     result;

    modport producer (
        output valid, pc, dest, wen, result
    );

    modport consumer (
        input valid, pc, dest, wen, result
    );

    // decode only needs what identifies a pending write
    modport bypass (
        input valid, dest, wen, result
    );
endinterface

`default_nettype wire

/* source/lite_core_pkg.sv */
`default_nettype none

package lite_core_pkg;

    localparam int word_w = 32;
    localparam int reg_addr_w = 5;

    typedef logic [word_w-1:0] word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_nor,
        alu_and,
        alu_or,
        alu_xor,
        alu_lui,
        alu_no_op
    } alu_op_e;

    // major opcodes of the three-register group, bits 31:15
    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [16:0] op_slt   = 17'h00024;
    localparam logic [16:0] op_sltu  = 17'h00025;
    localparam logic [16:0] op_nor   = 17'h00028;
    localparam logic [16:0] op_and   = 17'h00029;
    localparam logic [16:0] op_or    = 17'h0002a;
    localparam logic [16:0] op_xor   = 17'h0002b;

    // bits 31:22
    localparam logic [9:0] op_addi = 10'h00a;
    // bits 31:25
    localparam logic [6:0] op_lu12i = 7'h0a;

    localparam logic [3:0] trace_wen_all = 4'hf;

endpackage

`default_nettype wire
